// File: Bender.yml
package:
  name: wb_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/wb_pkg.sv
      - hw/inst_splitter.sv
      - hw/w_logic.sv
      - hw/load_extend.sv
      - hw/io_counters.sv
      - hw/wb_mux.sv
      - hw/wb_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_clock.sv
      - tests/tb_wb_stage.sv

// File: hw/inst_splitter.sv
module inst_splitter (
    input  wb_pkg::inst_t        inst,
    output wb_pkg::inst_fields_t fields
);

    wb_pkg::opcode_e opcode;

    // Opcode and funct fields sit at the same bit positions in every layout
    assign opcode = wb_pkg::opcode_e'(inst.r_fmt.opcode);

    assign fields.opcode = opcode;
    assign fields.rd     = inst.u_fmt.rd;
    assign fields.funct3 = inst.i_fmt.funct3;
    assign fields.rs1    = inst.i_fmt.rs1;
    assign fields.rs2    = inst.s_fmt.rs2;
    assign fields.funct7 = inst.r_fmt.funct7;

    // Format class from the opcode alone
    always_comb begin
        case (opcode)
            wb_pkg::OPC_OP: begin
                fields.fmt = wb_pkg::FMT_R;
            end
            wb_pkg::OPC_STORE: begin
                fields.fmt = wb_pkg::FMT_S;
            end
            wb_pkg::OPC_BRANCH: begin
                fields.fmt = wb_pkg::FMT_B;
            end
            wb_pkg::OPC_LUI, wb_pkg::OPC_AUIPC: begin
                fields.fmt = wb_pkg::FMT_U;
            end
            wb_pkg::OPC_JAL: begin
                fields.fmt = wb_pkg::FMT_J;
            end
            wb_pkg::OPC_SYSTEM: begin
                fields.fmt = wb_pkg::FMT_C;
            end
            // Loads, OP_IMM, JALR and anything unrecognised
            default: begin
                fields.fmt = wb_pkg::FMT_I;
            end
        endcase
    end

endmodule

// File: hw/io_counters.sv
`include "wb_params.svh"

module io_counters (
    input  logic                clk,
    input  logic                reset,
    input  wb_pkg::x_stage_t    x_in,
    input  logic                retire,
    output logic [`WB_XLEN-1:0] cycle_cnt,
    output logic [`WB_XLEN-1:0] instr_cnt
);

    logic cnt_clear;

    // The clear is taken from execute so the counters read zero
    // in the cycle right after the store reaches W
    assign cnt_clear = x_in.valid
                       && x_in.inst.s_fmt.opcode == wb_pkg::OPC_STORE
                       && x_in.alu == `WB_CNT_RESET_ADDR;

    // ----------------------------------------
    // Cycle counter
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset || cnt_clear) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Retired instruction counter
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset || cnt_clear) begin
            instr_cnt <= '0;
        end else if (retire) begin
            instr_cnt <= instr_cnt + 1'b1;
        end
    end

endmodule

// File: hw/load_extend.sv
`include "wb_params.svh"

module load_extend (
    input  logic [2:0]          funct3,
    input  logic [1:0]          byte_off,
    input  logic [`WB_XLEN-1:0] raw,
    output logic [`WB_XLEN-1:0] data
);

    localparam logic [2:0] FUNCT3_LB  = 3'h0;
    localparam logic [2:0] FUNCT3_LH  = 3'h1;
    localparam logic [2:0] FUNCT3_LBU = 3'h4;
    localparam logic [2:0] FUNCT3_LHU = 3'h5;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // ----------------------------------------
    // Lane selection
    // ----------------------------------------

    assign byte_lane = raw[{byte_off, 3'b000} +: 8];

    // Halfword loads are assumed aligned, so only bit 1 matters
    assign half_lane = byte_off[1] ? raw[31:16] : raw[15:0];

    // ----------------------------------------
    // Extension
    // ----------------------------------------

    always_comb begin
        case (funct3)
            FUNCT3_LB: begin
                data = {{(`WB_XLEN-8){byte_lane[7]}}, byte_lane};
            end
            FUNCT3_LH: begin
                data = {{(`WB_XLEN-16){half_lane[15]}}, half_lane};
            end
            FUNCT3_LBU: begin
                data = {{(`WB_XLEN-8){1'b0}}, byte_lane};
            end
            FUNCT3_LHU: begin
                data = {{(`WB_XLEN-16){1'b0}}, half_lane};
            end
            // LW and any unused encoding pass the word through
            default: begin
                data = raw;
            end
        endcase
    end

endmodule

// File: hw/w_logic.sv
`include "wb_params.svh"

module w_logic (
    input  wb_pkg::inst_fields_t fields,
    input  logic                 valid,
    input  wb_pkg::inst_t        inst_fd,
    input  logic [`WB_XLEN-1:0]  addr,
    input  logic                 br_taken,
    input  logic                 bios_reset,
    output wb_pkg::w_ctrl_t      ctrl,
    output wb_pkg::pc_sel_e      pc_sel,
    output logic                 flush
);

    localparam logic [2:0] FUNCT3_CSRRWI = 3'h5;

    logic            is_jal_fd;
    logic            is_jalr_w;
    logic            is_jal_w;
    logic            is_bios_addr;
    wb_pkg::wb_sel_e load_sel;

    // JAL is resolved in fetch/decode, so its opcode is checked there
    assign is_jal_fd    = inst_fd.j_fmt.opcode == wb_pkg::OPC_JAL;
    assign is_jalr_w    = fields.opcode == wb_pkg::OPC_JALR;
    assign is_jal_w     = fields.opcode == wb_pkg::OPC_JAL;
    assign is_bios_addr = addr[`WB_XLEN-1:`WB_XLEN-4] == `WB_BIOS_TAG;

    assign flush = br_taken;

    // ----------------------------------------
    // Next PC select
    // ----------------------------------------

    always_comb begin
        if (bios_reset) begin
            pc_sel = wb_pkg::BIOS_RESET;
        end else if (is_jal_fd) begin
            pc_sel = wb_pkg::JAL_TARGET;
        end else if (is_jalr_w) begin
            pc_sel = wb_pkg::ALU_TARGET;
        end else if (fields.fmt == wb_pkg::FMT_B && br_taken) begin
            pc_sel = wb_pkg::ALU_TARGET;
        end else begin
            pc_sel = wb_pkg::PC_PLUS_4;
        end
    end

    // ----------------------------------------
    // Load source decode
    // ----------------------------------------

    always_comb begin
        case (addr)
            `WB_UART_CTRL_ADDR: load_sel = wb_pkg::WB_UART_CTRL;
            `WB_UART_RX_ADDR:   load_sel = wb_pkg::WB_UART_RX;
            `WB_CYCLE_ADDR:     load_sel = wb_pkg::WB_CYCLE_CNT;
            `WB_INSTR_ADDR:     load_sel = wb_pkg::WB_INSTR_CNT;
            default: begin
                if (is_bios_addr) begin
                    load_sel = wb_pkg::WB_BIOS;
                end else begin
                    load_sel = wb_pkg::WB_DMEM;
                end
            end
        endcase
    end

    // ----------------------------------------
    // Write-back control word
    // ----------------------------------------

    always_comb begin
        // Stores, branches and system instructions leave the register file alone
        case (fields.fmt)
            wb_pkg::FMT_R, wb_pkg::FMT_I, wb_pkg::FMT_U, wb_pkg::FMT_J: begin
                ctrl.reg_wen = valid;
            end
            default: begin
                ctrl.reg_wen = 1'b0;
            end
        endcase

        ctrl.csr_wen = valid && fields.opcode == wb_pkg::OPC_SYSTEM;
        // Immediate form takes zimm, the others take rs1
        ctrl.csr_sel = fields.funct3 == FUNCT3_CSRRWI;

        if (fields.opcode == wb_pkg::OPC_LOAD) begin
            ctrl.wb_sel = load_sel;
        end else if (is_jal_w || is_jalr_w) begin
            ctrl.wb_sel = wb_pkg::WB_PC_PLUS_4;
        end else begin
            ctrl.wb_sel = wb_pkg::WB_ALU;
        end
    end

endmodule

// File: hw/wb_mux.sv
`include "wb_params.svh"

module wb_mux (
    input  wb_pkg::wb_sel_e     wb_sel,
    input  logic                csr_sel,
    input  logic [`WB_XLEN-1:0] pc,
    input  logic [`WB_XLEN-1:0] alu,
    input  logic [`WB_XLEN-1:0] load_data,
    input  logic [`WB_XLEN-1:0] uart_rx_data,
    input  logic [`WB_XLEN-1:0] uart_ctrl,
    input  logic [`WB_XLEN-1:0] cycle_cnt,
    input  logic [`WB_XLEN-1:0] instr_cnt,
    input  logic [`WB_XLEN-1:0] rs1_data,
    input  logic [4:0]          zimm,
    output logic [`WB_XLEN-1:0] wb_data,
    output logic [`WB_XLEN-1:0] csr_data
);

    logic [`WB_XLEN-1:0] pc_plus_4;

    // Link address for JAL and JALR
    assign pc_plus_4 = pc + `WB_XLEN'd4;

    // Memory data already went through the load extender,
    // so DMEM and BIOS share one source here
    always_comb begin
        case (wb_sel)
            wb_pkg::WB_PC_PLUS_4: wb_data = pc_plus_4;
            wb_pkg::WB_ALU:       wb_data = alu;
            wb_pkg::WB_DMEM:      wb_data = load_data;
            wb_pkg::WB_UART_RX:   wb_data = uart_rx_data;
            wb_pkg::WB_UART_CTRL: wb_data = uart_ctrl;
            wb_pkg::WB_BIOS:      wb_data = load_data;
            wb_pkg::WB_CYCLE_CNT: wb_data = cycle_cnt;
            wb_pkg::WB_INSTR_CNT: wb_data = instr_cnt;
            default:              wb_data = alu;
        endcase
    end

    assign csr_data = csr_sel ? {{(`WB_XLEN-5){1'b0}}, zimm} : rs1_data;

endmodule

// File: hw/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// ----------------------------------------
// Datapath width
// ----------------------------------------

`define WB_XLEN 32

// ----------------------------------------
// Memory-mapped I/O addresses
// ----------------------------------------

// UART status word and receive data
`define WB_UART_CTRL_ADDR 32'h8000_0000
`define WB_UART_RX_ADDR 32'h8000_0004

// Performance counters, readable by loads
`define WB_CYCLE_ADDR 32'h8000_0010
`define WB_INSTR_ADDR 32'h8000_0014

// A store here clears both performance counters
`define WB_CNT_RESET_ADDR 32'h8000_0018

// ----------------------------------------
// Address regions
// ----------------------------------------

// Loads whose address top nibble matches this tag read BIOS memory
`define WB_BIOS_TAG 4'h4

`endif

// File: hw/wb_pkg.sv
`include "wb_params.svh"

package wb_pkg;

    // ----------------------------------------
    // Opcodes and format classes
    // ----------------------------------------

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'h03,
        OPC_OP_IMM = 7'h13,
        OPC_AUIPC  = 7'h17,
        OPC_STORE  = 7'h23,
        OPC_OP     = 7'h33,
        OPC_LUI    = 7'h37,
        OPC_BRANCH = 7'h63,
        OPC_JALR   = 7'h67,
        OPC_JAL    = 7'h6f,
        OPC_SYSTEM = 7'h73
    } opcode_e;

    // C is the CSR and system class
    typedef enum logic [2:0] {
        FMT_R = 3'd0,
        FMT_I = 3'd1,
        FMT_S = 3'd2,
        FMT_B = 3'd3,
        FMT_U = 3'd4,
        FMT_J = 3'd5,
        FMT_C = 3'd6
    } inst_fmt_e;

    // ----------------------------------------
    // Instruction word layouts
    // ----------------------------------------

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word seen through every encoding
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rd;
        logic [2:0] funct3;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [6:0] funct7;
        inst_fmt_e  fmt;
    } inst_fields_t;

    // ----------------------------------------
    // Select codes
    // ----------------------------------------

    typedef enum logic [1:0] {
        PC_PLUS_4  = 2'd0,
        ALU_TARGET = 2'd1,
        JAL_TARGET = 2'd2,
        BIOS_RESET = 2'd3
    } pc_sel_e;

    typedef enum logic [2:0] {
        WB_PC_PLUS_4 = 3'd0,
        WB_ALU       = 3'd1,
        WB_DMEM      = 3'd2,
        WB_UART_RX   = 3'd3,
        WB_UART_CTRL = 3'd4,
        WB_BIOS      = 3'd5,
        WB_CYCLE_CNT = 3'd6,
        WB_INSTR_CNT = 3'd7
    } wb_sel_e;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------

    typedef struct packed {
        logic                valid;
        inst_t               inst;
        logic [`WB_XLEN-1:0] pc;
        logic [`WB_XLEN-1:0] alu;
        logic [`WB_XLEN-1:0] rs1_data;
    } x_stage_t;

    typedef struct packed {
        logic    reg_wen;
        logic    csr_wen;
        logic    csr_sel;
        wb_sel_e wb_sel;
    } w_ctrl_t;

endpackage

// File: hw/wb_stage.sv
`include "wb_params.svh"

module wb_stage (
    input  logic                clk,
    input  logic                reset,
    input  wb_pkg::x_stage_t    x_in,
    input  wb_pkg::inst_t       inst_fd,
    input  logic                br_taken,
    input  logic                bios_reset,
    input  logic [`WB_XLEN-1:0] dmem_rdata,
    input  logic [`WB_XLEN-1:0] bios_rdata,
    input  logic [`WB_XLEN-1:0] uart_rx_data,
    input  logic [`WB_XLEN-1:0] uart_ctrl,
    output logic                reg_wen,
    output logic [4:0]          rd,
    output logic [`WB_XLEN-1:0] wb_data,
    output logic                csr_wen,
    output logic [`WB_XLEN-1:0] csr_data,
    output wb_pkg::pc_sel_e     pc_sel,
    output logic                flush
);

    wb_pkg::x_stage_t     w_reg;
    wb_pkg::inst_fields_t fields;
    wb_pkg::w_ctrl_t      ctrl;
    logic [`WB_XLEN-1:0]  load_raw;
    logic [`WB_XLEN-1:0]  load_data;
    logic [`WB_XLEN-1:0]  cycle_cnt;
    logic [`WB_XLEN-1:0]  instr_cnt;

    // ----------------------------------------
    // W register
    // ----------------------------------------

    // Reset turns W into a bubble
    always_ff @(posedge clk) begin
        w_reg <= x_in;
        if (reset) begin
            w_reg.valid <= 1'b0;
        end
    end

    // ----------------------------------------
    // Decode and control
    // ----------------------------------------

    inst_splitter inst_splitter_i (
        .inst   (w_reg.inst),
        .fields (fields)
    );

    w_logic w_logic_i (
        .fields     (fields),
        .valid      (w_reg.valid),
        .inst_fd    (inst_fd),
        .addr       (w_reg.alu),
        .br_taken   (br_taken),
        .bios_reset (bios_reset),
        .ctrl       (ctrl),
        .pc_sel     (pc_sel),
        .flush      (flush)
    );

    // ----------------------------------------
    // Data path
    // ----------------------------------------

    assign load_raw = (ctrl.wb_sel == wb_pkg::WB_BIOS) ? bios_rdata : dmem_rdata;

    load_extend load_extend_i (
        .funct3   (fields.funct3),
        .byte_off (w_reg.alu[1:0]),
        .raw      (load_raw),
        .data     (load_data)
    );

    io_counters io_counters_i (
        .clk       (clk),
        .reset     (reset),
        .x_in      (x_in),
        .retire    (w_reg.valid),
        .cycle_cnt (cycle_cnt),
        .instr_cnt (instr_cnt)
    );

    // The rs1 field doubles as the 5-bit CSR immediate
    wb_mux wb_mux_i (
        .wb_sel       (ctrl.wb_sel),
        .csr_sel      (ctrl.csr_sel),
        .pc           (w_reg.pc),
        .alu          (w_reg.alu),
        .load_data    (load_data),
        .uart_rx_data (uart_rx_data),
        .uart_ctrl    (uart_ctrl),
        .cycle_cnt    (cycle_cnt),
        .instr_cnt    (instr_cnt),
        .rs1_data     (w_reg.rs1_data),
        .zimm         (fields.rs1),
        .wb_data      (wb_data),
        .csr_data     (csr_data)
    );

    assign reg_wen = ctrl.reg_wen;
    assign csr_wen = ctrl.csr_wen;
    assign rd      = fields.rd;

endmodule

// File: tb.f
+incdir+hw
hw/wb_pkg.sv
hw/inst_splitter.sv
hw/w_logic.sv
hw/load_extend.sv
hw/io_counters.sv
hw/wb_mux.sv
hw/wb_stage.sv
tests/tb_clock.sv
tests/tb_wb_stage.sv

// File: tests/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset covers the first three rising edges and drops on a falling edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: tests/tb_wb_stage.sv
`include "wb_params.svh"

module tb_wb_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 10;
    localparam int EDGE_LIMIT  = 4;
    localparam int RESET_LIMIT = 10;
    localparam int RANDOM_RUNS = 200;

    logic                clk;
    logic                reset;
    wb_pkg::x_stage_t    x_in;
    wb_pkg::inst_t       inst_fd;
    logic                br_taken;
    logic                bios_reset;
    logic [`WB_XLEN-1:0] dmem_rdata;
    logic [`WB_XLEN-1:0] bios_rdata;
    logic [`WB_XLEN-1:0] uart_rx_data;
    logic [`WB_XLEN-1:0] uart_ctrl;
    logic                reg_wen;
    logic [4:0]          rd;
    logic [`WB_XLEN-1:0] wb_data;
    logic                csr_wen;
    logic [`WB_XLEN-1:0] csr_data;
    wb_pkg::pc_sel_e     pc_sel;
    logic                flush;

    // Reference copy of the W register and both counters
    wb_pkg::x_stage_t    model_w;
    logic [`WB_XLEN-1:0] model_cycles;
    logic [`WB_XLEN-1:0] model_retired;

    logic [31:0] rng_state;
    int          checks;
    int          phase_errors;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;
    bit          timed_out;

    tb_clock tb_clock_i (
        .clk   (clk),
        .reset (reset)
    );

    wb_stage wb_stage_i (
        .clk          (clk),
        .reset        (reset),
        .x_in         (x_in),
        .inst_fd      (inst_fd),
        .br_taken     (br_taken),
        .bios_reset   (bios_reset),
        .dmem_rdata   (dmem_rdata),
        .bios_rdata   (bios_rdata),
        .uart_rx_data (uart_rx_data),
        .uart_ctrl    (uart_ctrl),
        .reg_wen      (reg_wen),
        .rd           (rd),
        .wb_data      (wb_data),
        .csr_wen      (csr_wen),
        .csr_data     (csr_data),
        .pc_sel       (pc_sel),
        .flush        (flush)
    );

    // ----------------------------------------
    // Random stimulus
    // ----------------------------------------

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic wb_pkg::opcode_e random_opcode();
        case (next_random() % 10)
            0: return wb_pkg::OPC_LOAD;
            1: return wb_pkg::OPC_OP_IMM;
            2: return wb_pkg::OPC_OP;
            3: return wb_pkg::OPC_STORE;
            4: return wb_pkg::OPC_BRANCH;
            5: return wb_pkg::OPC_LUI;
            6: return wb_pkg::OPC_AUIPC;
            7: return wb_pkg::OPC_JAL;
            8: return wb_pkg::OPC_JALR;
            default: return wb_pkg::OPC_SYSTEM;
        endcase
    endfunction

    function automatic logic [2:0] random_load_funct3();
        case (next_random() % 5)
            0: return 3'h0;
            1: return 3'h1;
            2: return 3'h4;
            3: return 3'h5;
            default: return 3'h2;
        endcase
    endfunction

    // Three of every four addresses land on MMIO registers or in BIOS space
    function automatic logic [31:0] random_addr();
        logic [31:0] pick;
        logic [31:0] low;
        pick = next_random();
        low  = next_random();
        case (pick[2:0])
            3'd0: return `WB_UART_CTRL_ADDR;
            3'd1: return `WB_UART_RX_ADDR;
            3'd2: return `WB_CYCLE_ADDR;
            3'd3: return `WB_INSTR_ADDR;
            3'd4: return `WB_CNT_RESET_ADDR;
            3'd5: return {`WB_BIOS_TAG, low[27:0]};
            default: return low;
        endcase
    endfunction

    function automatic wb_pkg::x_stage_t random_x(logic valid, wb_pkg::opcode_e opcode,
                                                  logic [2:0] funct3);
        wb_pkg::x_stage_t x;
        x.valid             = valid;
        x.inst              = next_random();
        x.inst.r_fmt.opcode = opcode;
        x.inst.r_fmt.funct3 = funct3;
        x.pc                = next_random() & 32'hffff_fffc;
        x.alu               = random_addr();
        x.rs1_data          = next_random();
        return x;
    endfunction

    function automatic wb_pkg::x_stage_t bubble();
        return random_x(1'b0, wb_pkg::OPC_OP, 3'h0);
    endfunction

    function automatic wb_pkg::inst_t random_fd();
        wb_pkg::inst_t fd;
        fd = next_random();
        if (next_random() % 4 == 0) begin
            fd.j_fmt.opcode = wb_pkg::OPC_JAL;
        end else begin
            fd.j_fmt.opcode = wb_pkg::OPC_OP;
        end
        return fd;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic logic [31:0] extend_load(logic [2:0] funct3, logic [1:0] off,
                                                logic [31:0] word);
        logic [7:0]  byte_val;
        logic [15:0] half_val;
        byte_val = 8'(word >> (8 * off));
        half_val = 16'(word >> (16 * off[1]));
        case (funct3)
            3'h0: return {{24{byte_val[7]}}, byte_val};
            3'h1: return {{16{half_val[15]}}, half_val};
            3'h4: return {24'h0, byte_val};
            3'h5: return {16'h0, half_val};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] expected_wb_data();
        logic [6:0] opcode;
        logic [2:0] funct3;
        opcode = model_w.inst.r_fmt.opcode;
        funct3 = model_w.inst.r_fmt.funct3;
        if (opcode == wb_pkg::OPC_JAL || opcode == wb_pkg::OPC_JALR) begin
            return model_w.pc + 32'd4;
        end
        if (opcode != wb_pkg::OPC_LOAD) begin
            return model_w.alu;
        end
        case (model_w.alu)
            `WB_UART_CTRL_ADDR: return uart_ctrl;
            `WB_UART_RX_ADDR:   return uart_rx_data;
            `WB_CYCLE_ADDR:     return model_cycles;
            `WB_INSTR_ADDR:     return model_retired;
            default: begin
                if (model_w.alu[31:28] == `WB_BIOS_TAG) begin
                    return extend_load(funct3, model_w.alu[1:0], bios_rdata);
                end
                return extend_load(funct3, model_w.alu[1:0], dmem_rdata);
            end
        endcase
    endfunction

    // Advances the model across the coming rising edge
    task automatic step_model();
        logic clear;
        clear = x_in.valid && x_in.inst.s_fmt.opcode == wb_pkg::OPC_STORE
                && x_in.alu == `WB_CNT_RESET_ADDR;
        if (reset || clear) begin
            model_cycles  = '0;
            model_retired = '0;
        end else begin
            model_cycles = model_cycles + 1;
            if (model_w.valid) begin
                model_retired = model_retired + 1;
            end
        end
        model_w = x_in;
        if (reset) begin
            model_w.valid = 1'b0;
        end
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------

    task automatic note_error();
        phase_errors++;
        total_errors++;
    endtask

    task automatic check_wb(string name, logic [4:0] got_rd, logic [4:0] exp_rd,
                            logic [`WB_XLEN-1:0] got, logic [`WB_XLEN-1:0] exp);
        checks++;
        if (got_rd !== exp_rd) begin
            $display("** Error: rd = %h, expected %h", got_rd, exp_rd);
            note_error();
        end
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h (rd %h)", name, got, exp, exp_rd);
            note_error();
        end
    endtask

    task automatic check_ctrl(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            note_error();
        end
    endtask

    task automatic check_pc_sel(wb_pkg::pc_sel_e got, wb_pkg::pc_sel_e exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: pc_sel = %h, expected %h", got, exp);
            note_error();
        end
    endtask

    task automatic check_cnt(string name, logic [`WB_XLEN-1:0] got, logic [`WB_XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: wb_data = %h, expected %h (%s)", got, exp, name);
            note_error();
        end
    endtask

    task automatic check_outputs();
        logic [6:0]      opcode;
        logic            exp_reg_wen;
        logic            exp_csr_wen;
        logic [31:0]     exp_data;
        wb_pkg::pc_sel_e exp_pc_sel;
        opcode      = model_w.inst.r_fmt.opcode;
        exp_reg_wen = model_w.valid && opcode != wb_pkg::OPC_STORE
                      && opcode != wb_pkg::OPC_BRANCH && opcode != wb_pkg::OPC_SYSTEM;
        exp_csr_wen = model_w.valid && opcode == wb_pkg::OPC_SYSTEM;
        check_ctrl("reg_wen", reg_wen, exp_reg_wen);
        check_ctrl("csr_wen", csr_wen, exp_csr_wen);
        check_ctrl("flush", flush, br_taken);

        if (bios_reset) begin
            exp_pc_sel = wb_pkg::BIOS_RESET;
        end else if (inst_fd.j_fmt.opcode == wb_pkg::OPC_JAL) begin
            exp_pc_sel = wb_pkg::JAL_TARGET;
        end else if (opcode == wb_pkg::OPC_JALR
                     || (opcode == wb_pkg::OPC_BRANCH && br_taken)) begin
            exp_pc_sel = wb_pkg::ALU_TARGET;
        end else begin
            exp_pc_sel = wb_pkg::PC_PLUS_4;
        end
        check_pc_sel(pc_sel, exp_pc_sel);

        if (exp_reg_wen) begin
            exp_data = expected_wb_data();
            if (opcode == wb_pkg::OPC_LOAD && model_w.alu == `WB_CYCLE_ADDR) begin
                check_cnt("cycle count", wb_data, exp_data);
            end else if (opcode == wb_pkg::OPC_LOAD && model_w.alu == `WB_INSTR_ADDR) begin
                check_cnt("retired count", wb_data, exp_data);
            end else begin
                check_wb("wb_data", rd, model_w.inst.r_fmt.rd, wb_data, exp_data);
            end
        end

        // CSRRWI takes the rs1 field as a zero-extended immediate
        if (exp_csr_wen) begin
            if (model_w.inst.r_fmt.funct3 == 3'h5) begin
                exp_data = {27'h0, model_w.inst.r_fmt.rs1};
            end else begin
                exp_data = model_w.rs1_data;
            end
            check_wb("csr_data", rd, model_w.inst.r_fmt.rd, csr_data, exp_data);
        end
    endtask

    // ----------------------------------------
    // Cycle sequencing
    // ----------------------------------------

    // Follows clock changes until a high phase has been seen and the clock is low
    task automatic wait_falling_edge();
        int changes;
        bit seen_high;
        changes   = 0;
        seen_high = 1'b0;
        do begin
            @(clk);
            changes++;
            if (clk === 1'b1) begin
                seen_high = 1'b1;
            end
        end while (!(seen_high && clk === 1'b0) && changes < EDGE_LIMIT);
        if (!(seen_high && clk === 1'b0)) begin
            $display("Clock did not fall within %0d transitions", EDGE_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic drive_cycle(wb_pkg::x_stage_t x, wb_pkg::inst_t fd, logic br, logic bios);
        if (!timed_out) begin
            wait_falling_edge();
        end
        if (!timed_out) begin
            x_in         = x;
            inst_fd      = fd;
            br_taken     = br;
            bios_reset   = bios;
            dmem_rdata   = next_random();
            bios_rdata   = next_random();
            uart_rx_data = next_random();
            uart_ctrl    = next_random();
            // Outputs settle well before the next rising edge
            #(HALF_PERIOD - 1);
            check_outputs();
            step_model();
        end
    endtask

    task automatic finish_phase(string name);
        drive_cycle(bubble(), '0, 1'b0, 1'b0);
        if (phase_errors == 0 && !timed_out) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, phase_errors);
        end
        phase_errors = 0;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        wb_pkg::x_stage_t x;
        wb_pkg::opcode_e  op;
        logic [2:0]       f3;
        int               waited;

        x_in          = '0;
        inst_fd       = '0;
        br_taken      = 1'b0;
        bios_reset    = 1'b0;
        dmem_rdata    = '0;
        bios_rdata    = '0;
        uart_rx_data  = '0;
        uart_ctrl     = '0;
        model_w       = '0;
        model_cycles  = '0;
        model_retired = '0;
        rng_state     = 32'hf640470d;
        checks        = 0;
        phase_errors  = 0;
        total_errors  = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        timed_out     = 1'b0;

        waited = 0;
        while (reset !== 1'b0 && waited < RESET_LIMIT && !timed_out) begin
            // Valid instructions presented during reset must not reach W
            x = random_x(1'b1, random_opcode(), 3'(next_random()));
            drive_cycle(x, '0, 1'b0, 1'b0);
            waited++;
        end
        if (reset !== 1'b0) begin
            $display("Reset did not deassert within %0d cycles", RESET_LIMIT);
            timed_out = 1'b1;
        end
        x = random_x(1'b1, wb_pkg::OPC_LOAD, 3'h2);
        x.alu = `WB_CYCLE_ADDR;
        drive_cycle(x, '0, 1'b0, 1'b0);
        finish_phase("reset state");

        for (int i = 0; i < RANDOM_RUNS; i++) begin
            op = random_opcode();
            if (op == wb_pkg::OPC_LOAD || op == wb_pkg::OPC_SYSTEM) begin
                op = wb_pkg::OPC_OP;
            end
            x = random_x(next_random() % 4 != 0, op, 3'(next_random()));
            drive_cycle(x, random_fd(), 1'(next_random()), 1'b0);
        end
        finish_phase("register writes");

        for (int i = 0; i < RANDOM_RUNS; i++) begin
            x = random_x(next_random() % 8 != 0, wb_pkg::OPC_LOAD, random_load_funct3());
            drive_cycle(x, random_fd(), 1'b0, 1'b0);
        end
        finish_phase("loads");

        for (int round = 0; round < 4; round++) begin
            for (int i = 0; i < 10; i++) begin
                x = random_x(1'(next_random()), random_opcode(), 3'(next_random()));
                drive_cycle(x, '0, 1'b0, 1'b0);
            end
            x = random_x(1'b1, wb_pkg::OPC_STORE, 3'h2);
            x.alu = `WB_CNT_RESET_ADDR;
            drive_cycle(x, '0, 1'b0, 1'b0);
            x = random_x(1'b1, wb_pkg::OPC_LOAD, 3'h2);
            x.alu = `WB_CYCLE_ADDR;
            drive_cycle(x, '0, 1'b0, 1'b0);
            x.alu = `WB_INSTR_ADDR;
            drive_cycle(x, '0, 1'b0, 1'b0);
        end
        finish_phase("counters");

        for (int i = 0; i < RANDOM_RUNS; i++) begin
            case (next_random() % 3)
                0: op = wb_pkg::OPC_JALR;
                1: op = wb_pkg::OPC_BRANCH;
                default: op = random_opcode();
            endcase
            x = random_x(1'(next_random()), op, 3'(next_random()));
            drive_cycle(x, random_fd(), 1'(next_random()), next_random() % 4 == 0);
        end
        finish_phase("next pc and flush");

        for (int i = 0; i < RANDOM_RUNS / 2; i++) begin
            f3 = 3'(next_random());
            if (f3 == 3'h0 || f3 == 3'h4) begin
                f3 = 3'h5;
            end
            x = random_x(1'b1, wb_pkg::OPC_SYSTEM, f3);
            drive_cycle(x, '0, 1'b0, 1'b0);
        end
        finish_phase("csr");

        $display("%0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, total_errors);
        if (!timed_out && total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
